//--- include/mcTable.svh
// -------------------------------------------------------------------
// Microcode table, included inside the ROM module. mcWord packs the
// fields of one microword, mcTable gives the word of an opcode step
// -------------------------------------------------------------------
`ifndef MC_TABLE_SVH
`define MC_TABLE_SVH

function automatic mcWord_t mcWord(
    input logic [1:0] memOp,
    input logic [2:0] srcSel,
    input logic [2:0] dstSel,
    input logic [1:0] addrSel,
    input logic [1:0] pcOp,
    input logic       aluAdd,
    input logic       last,
    input logic       halt
);
    mcWord_t w;
    w = '0;
    w[MC_MEMOP_LO +: 2] = memOp;
    w[MC_SRC_LO +: 3]   = srcSel;
    w[MC_DST_LO +: 3]   = dstSel;
    w[MC_ADDR_LO +: 2]  = addrSel;
    w[MC_PC_LO +: 2]    = pcOp;
    w[MC_ADD_BIT]       = aluAdd;
    w[MC_LAST_BIT]      = last;
    w[MC_HALT_BIT]      = halt;
    return w;
endfunction

function automatic mcWord_t mcTable(input byte_t op, input logic [1:0] step);
    mcWord_t w;
    w = mcWord(MEM_NONE, SRC_NONE, DST_NONE, ADDR_PC, PC_HOLD, 1'b0, 1'b0, 1'b1);
    case (op)
        OP_LDAI, OP_ADDI: begin
            if (step == 2'd0) begin
                w = mcWord(MEM_RD, SRC_NONE, DST_A, ADDR_PC, PC_INC, op == OP_ADDI,
                           1'b1, 1'b0);
            end
        end
        OP_STAE, OP_JMPE: begin
            if (step == 2'd0) begin // Operand high byte
                w = mcWord(MEM_RD, SRC_NONE, DST_TH, ADDR_PC, PC_INC, 1'b0, 1'b0, 1'b0);
            end else if (step == 2'd1) begin
                w = mcWord(MEM_RD, SRC_NONE, DST_TL, ADDR_PC, PC_INC, 1'b0, 1'b0, 1'b0);
            end else if (step == 2'd2 && op == OP_STAE) begin
                w = mcWord(MEM_WR, SRC_A, DST_NONE, ADDR_T, PC_HOLD, 1'b0, 1'b1, 1'b0);
            end else if (step == 2'd2) begin
                w = mcWord(MEM_NONE, SRC_NONE, DST_NONE, ADDR_PC, PC_LDT, 1'b0, 1'b1, 1'b0);
            end
        end
        OP_NOP: begin
            if (step == 2'd0) begin
                w = mcWord(MEM_NONE, SRC_NONE, DST_NONE, ADDR_PC, PC_HOLD, 1'b0, 1'b1, 1'b0);
            end
        end
        default: ;
    endcase
    return w;
endfunction

`endif

//--- hw/mcPkg.sv
// -------------------------------------------------------------------
// Shared types and constants of the microcoded 8-bit core. Holds the
// widths, phases, opcodes, microword layout and vector addresses
// -------------------------------------------------------------------
`default_nettype none

package mcPkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [17:0] mcWord_t;

    localparam int CEN_DIV = 4; // Clocks per phase step
    localparam int CEN_W   = $clog2(CEN_DIV);

    typedef enum logic [3:0] {
        PH_RST, PH_VECT, PH_VEC1, PH_VEC2,
        PH_FETCH, PH_EXEC0, PH_EXEC1, PH_EXEC2, PH_EXEC3,
        PH_INTR0, PH_INTR1, PH_INTR2, PH_INTR3,
        PH_HALT
    } phase_t;

    localparam byte_t OP_LDAI = 8'h86;
    localparam byte_t OP_ADDI = 8'h8B;
    localparam byte_t OP_STAE = 8'hB7;
    localparam byte_t OP_JMPE = 8'h7E;
    localparam byte_t OP_NOP  = 8'h01;

    localparam addr_t RESET_VEC = 16'hFFFE;
    localparam addr_t IRQ_VEC   = 16'hFFF8;
    localparam addr_t STACK_TOP = 16'h00FF;

    // Microword fields, top bit down; bits 2:0 spare
    localparam int MC_MEMOP_LO = 16;
    localparam int MC_SRC_LO   = 13;
    localparam int MC_DST_LO   = 10;
    localparam int MC_ADDR_LO  = 8;
    localparam int MC_PC_LO    = 6;
    localparam int MC_ADD_BIT  = 5;
    localparam int MC_LAST_BIT = 4;
    localparam int MC_HALT_BIT = 3;

    localparam logic [1:0] MEM_NONE = 2'd0;
    localparam logic [1:0] MEM_RD   = 2'd1;
    localparam logic [1:0] MEM_WR   = 2'd2;
    localparam logic [1:0] MEM_PSH  = 2'd3; // Write at SP, then SP-1

    localparam logic [2:0] SRC_NONE = 3'd0;
    localparam logic [2:0] SRC_A    = 3'd1;
    localparam logic [2:0] SRC_PCL  = 3'd2;
    localparam logic [2:0] SRC_PCH  = 3'd3;
    localparam logic [2:0] SRC_DR   = 3'd4;

    localparam logic [2:0] DST_NONE = 3'd0;
    localparam logic [2:0] DST_A    = 3'd1;
    localparam logic [2:0] DST_TH   = 3'd2;
    localparam logic [2:0] DST_TL   = 3'd3;
    localparam logic [2:0] DST_PCH  = 3'd4;
    localparam logic [2:0] DST_PCL  = 3'd5;
    localparam logic [2:0] DST_OP   = 3'd6;

    localparam logic [1:0] ADDR_PC  = 2'd0;
    localparam logic [1:0] ADDR_T   = 2'd1;
    localparam logic [1:0] ADDR_SP  = 2'd2;
    localparam logic [1:0] ADDR_VEC = 2'd3;

    localparam logic [1:0] PC_HOLD = 2'd0;
    localparam logic [1:0] PC_INC  = 2'd1;
    localparam logic [1:0] PC_LDT  = 2'd2;

endpackage

`default_nettype wire

//--- hw/busIf.sv
// -------------------------------------------------------------------
// Request and done handshake between the execution unit and the APB
// master. The core holds req and its payload until done
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface busIf import mcPkg::*; ();

    logic  req;
    logic  write;
    addr_t addr;
    byte_t wdata;
    byte_t rdata;
    logic  done; // One cycle, rdata valid with it

    modport core (output req, write, addr, wdata, input rdata, done);
    modport master (input req, write, addr, wdata, output rdata, done);

endinterface

`default_nettype wire

//--- hw/cenGen.sv
// -------------------------------------------------------------------
// Clock-enable generator. cenRise pulses once every CEN_DIV clocks
// and cenFall follows it two clocks later
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cenGen import mcPkg::*; (
    input  wire  clk,
    input  wire  rstN,
    output logic cenRise,
    output logic cenFall
);

    logic [CEN_W-1:0] cnt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt     <= '0;
            cenRise <= 1'b0;
            cenFall <= 1'b0;
        end else begin
            cnt     <= (cnt == CEN_W'(CEN_DIV - 1)) ? '0 : cnt + 1'b1;
            cenRise <= (cnt == CEN_W'(CEN_DIV - 1));
            cenFall <= (cnt == CEN_W'(1));
        end
    end

endmodule

`default_nettype wire

//--- hw/phaseSeq.sv
// -------------------------------------------------------------------
// Phase sequencer. phase is the phase taken at the next cenRise, so
// the ROM latches the same value that the state register takes
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module phaseSeq import mcPkg::*; (
    input  wire        clk,
    input  wire        rstN,
    input  wire        cenRise,
    input  wire        irq,
    input  wire        busy,
    input  wire byte_t opcode,
    input  wire        mcLast,
    input  wire        mcHalt,
    output phase_t     phase,
    output logic       halted
);

    phase_t state;
    phase_t boundary;
    logic   irqMask;
    logic   rstDone;

    // Interrupt only between instructions
    assign boundary = (irq && !irqMask) ? PH_INTR0 : PH_FETCH;

    always_comb begin
        phase = state;
        if (!busy) begin
            case (state)
                PH_RST:   phase = rstDone ? PH_VECT : PH_RST;
                PH_VECT:  phase = PH_VEC1;
                PH_VEC1:  phase = PH_VEC2;
                PH_VEC2:  phase = PH_FETCH;
                PH_FETCH: phase = (opcode == OP_NOP) ? boundary : PH_EXEC0;
                PH_EXEC0, PH_EXEC1, PH_EXEC2, PH_EXEC3: begin
                    if (mcHalt || (state == PH_EXEC3 && !mcLast)) begin
                        phase = PH_HALT;
                    end else if (mcLast) begin
                        phase = boundary;
                    end else begin
                        phase = phase_t'(state + 4'd1);
                    end
                end
                PH_INTR0: phase = PH_INTR1;
                PH_INTR1: phase = PH_INTR2;
                PH_INTR2: phase = PH_INTR3;
                PH_INTR3: phase = PH_VEC1; // Vector low byte, then PC load
                default:  phase = PH_HALT;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= PH_RST;
            irqMask <= 1'b0;
            rstDone <= 1'b0;
            halted  <= 1'b0;
        end else if (cenRise) begin
            state   <= phase;
            rstDone <= 1'b1;
            halted  <= (phase == PH_HALT);
            if (phase == PH_INTR0) begin
                irqMask <= 1'b1; // Held until reset
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mcRom.sv
// -------------------------------------------------------------------
// Microcode ROM. Registers the phase and the table lookup on cenRise
// and gives the microword one clock later
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mcRom import mcPkg::*; (
    input  wire         clk,
    input  wire         cenRise,
    input  wire phase_t phase,
    input  wire byte_t  opcode,
    output mcWord_t     mcode
);

`include "mcTable.svh"

    phase_t     p;
    mcWord_t    tbl;
    logic [1:0] step;

    always_comb begin
        case (phase)
            PH_EXEC1: step = 2'd1;
            PH_EXEC2: step = 2'd2;
            PH_EXEC3: step = 2'd3;
            default:  step = 2'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cenRise) begin
            p   <= phase;
            tbl <= mcTable(opcode, step);
        end
    end

    always_comb begin
        case (p)
            PH_RST: begin
                mcode = mcWord(MEM_NONE, SRC_NONE, DST_NONE, ADDR_PC, PC_HOLD, 1'b0, 1'b0, 1'b0);
            end
            PH_VECT, PH_INTR3: begin // Vector high byte
                mcode = mcWord(MEM_RD, SRC_NONE, DST_TH, ADDR_VEC, PC_HOLD, 1'b0, 1'b0, 1'b0);
            end
            PH_VEC1: begin
                mcode = mcWord(MEM_RD, SRC_NONE, DST_TL, ADDR_VEC, PC_HOLD, 1'b0, 1'b0, 1'b0);
            end
            PH_VEC2: begin
                mcode = mcWord(MEM_NONE, SRC_NONE, DST_NONE, ADDR_PC, PC_LDT, 1'b0, 1'b0, 1'b0);
            end
            PH_FETCH: begin
                mcode = mcWord(MEM_RD, SRC_NONE, DST_OP, ADDR_PC, PC_INC, 1'b0, 1'b0, 1'b0);
            end
            PH_EXEC0, PH_EXEC1, PH_EXEC2, PH_EXEC3: mcode = tbl;
            PH_INTR0: mcode = mcWord(MEM_PSH, SRC_PCL, DST_NONE, ADDR_SP, PC_HOLD, 1'b0, 1'b0, 1'b0);
            PH_INTR1: mcode = mcWord(MEM_PSH, SRC_PCH, DST_NONE, ADDR_SP, PC_HOLD, 1'b0, 1'b0, 1'b0);
            PH_INTR2: mcode = mcWord(MEM_PSH, SRC_A, DST_NONE, ADDR_SP, PC_HOLD, 1'b0, 1'b0, 1'b0);
            default: begin
                mcode = mcWord(MEM_NONE, SRC_NONE, DST_NONE, ADDR_PC, PC_HOLD, 1'b0, 1'b0, 1'b1);
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/execUnit.sv
// -------------------------------------------------------------------
// Execution unit. Starts a microword on cenFall, keeps it while its
// bus transfer runs and reports busy until the cenFall after done
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module execUnit import mcPkg::*; (
    input  wire          clk,
    input  wire          rstN,
    input  wire          cenFall,
    input  wire mcWord_t mcode,
    busIf.core           bus,
    output logic         busy,
    output byte_t        opcode,
    output logic         mcLast,
    output logic         mcHalt
);

    mcWord_t    mw; // Microword in execution
    logic [1:0] cMem;
    logic [1:0] cAddr;
    logic [1:0] cPc;
    logic [2:0] cSrc;
    logic [2:0] cDst;
    logic [2:0] hDst;
    byte_t      a;
    byte_t      dr;
    byte_t      srcVal;
    addr_t      pc;
    addr_t      sp;
    addr_t      t;
    addr_t      vecBase;
    addr_t      nextAddr;
    logic       fin;
    logic       vecIrq;
    logic       start;

    assign cMem    = mcode[MC_MEMOP_LO +: 2];
    assign cSrc    = mcode[MC_SRC_LO +: 3];
    assign cDst    = mcode[MC_DST_LO +: 3];
    assign cAddr   = mcode[MC_ADDR_LO +: 2];
    assign cPc     = mcode[MC_PC_LO +: 2];
    assign hDst    = mw[MC_DST_LO +: 3];
    assign mcLast  = mw[MC_LAST_BIT];
    assign mcHalt  = mw[MC_HALT_BIT];
    assign start   = cenFall && !busy;
    assign vecBase = vecIrq ? IRQ_VEC : RESET_VEC;

    always_comb begin
        case (cAddr)
            ADDR_PC: nextAddr = pc;
            ADDR_T:  nextAddr = t;
            ADDR_SP: nextAddr = sp;
            default: nextAddr = vecBase | addr_t'(cDst == DST_TL); // Low byte at +1
        endcase
        case (cSrc)
            SRC_A:   srcVal = a;
            SRC_PCL: srcVal = pc[7:0];
            SRC_PCH: srcVal = pc[15:8];
            SRC_DR:  srcVal = dr;
            default: srcVal = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mw      <= '0;
            busy    <= 1'b0;
            fin     <= 1'b0;
            bus.req <= 1'b0;
            vecIrq  <= 1'b0;
            a       <= '0;
            pc      <= '0;
            sp      <= STACK_TOP;
        end else begin
            if (start) begin
                mw <= mcode;
                if (cPc == PC_INC) begin
                    pc <= pc + 16'd1;
                end else if (cPc == PC_LDT) begin
                    pc     <= t;
                    vecIrq <= 1'b0;
                end
                if (cMem == MEM_PSH) begin
                    sp     <= sp - 16'd1;
                    vecIrq <= 1'b1; // Interrupt path selects IRQ_VEC
                end
                if (cMem != MEM_NONE) begin
                    bus.req <= 1'b1;
                    busy    <= 1'b1;
                end
            end else if (cenFall && fin) begin
                busy <= 1'b0;
                fin  <= 1'b0;
            end
            if (bus.done) begin
                bus.req <= 1'b0;
                fin     <= 1'b1;
                if (hDst == DST_A) begin
                    a <= mw[MC_ADD_BIT] ? a + bus.rdata : bus.rdata;
                end
                if (hDst == DST_PCH) begin
                    pc[15:8] <= bus.rdata;
                end
                if (hDst == DST_PCL) begin
                    pc[7:0] <= bus.rdata;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && cMem != MEM_NONE) begin
            bus.write <= (cMem == MEM_WR) || (cMem == MEM_PSH);
            bus.addr  <= nextAddr;
            bus.wdata <= srcVal;
        end
        if (bus.done) begin
            dr <= bus.rdata;
            if (hDst == DST_TH) begin
                t[15:8] <= bus.rdata;
            end
            if (hDst == DST_TL) begin
                t[7:0] <= bus.rdata;
            end
            if (hDst == DST_OP) begin
                opcode <= bus.rdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/apbMaster.sv
// -------------------------------------------------------------------
// APB master. Runs one setup and access sequence per request and
// pulses done with the read data after pready
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module apbMaster import mcPkg::*; (
    input  wire        clk,
    input  wire        rstN,
    busIf.master       bus,
    output addr_t      paddr,
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output byte_t      pwdata,
    input  wire byte_t prdata,
    input  wire        pready
);

    typedef enum logic [1:0] {AP_IDLE, AP_SETUP, AP_ACCESS} apbState_t;

    apbState_t state;

    assign psel    = (state != AP_IDLE);
    assign penable = (state == AP_ACCESS);
    assign paddr   = bus.addr;
    assign pwrite  = bus.write;
    assign pwdata  = bus.wdata;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= AP_IDLE;
            bus.done <= 1'b0;
        end else begin
            bus.done <= (state == AP_ACCESS) && pready;
            case (state)
                AP_IDLE:  state <= (bus.req && !bus.done) ? AP_SETUP : AP_IDLE; // req still up
                AP_SETUP: state <= AP_ACCESS;
                default:  state <= pready ? AP_IDLE : AP_ACCESS;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == AP_ACCESS && pready) begin
            bus.rdata <= prdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/mcCore.sv
// -------------------------------------------------------------------
// Top level of the microcoded 8-bit core. Memory goes out over APB,
// irq is a level input and halted rises on an unknown opcode
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mcCore import mcPkg::*; (
    input  wire        clk,
    input  wire        rstN,
    input  wire        irq,
    output addr_t      paddr,
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output byte_t      pwdata,
    input  wire byte_t prdata,
    input  wire        pready,
    output logic       halted
);

    logic    cenRise;
    logic    cenFall;
    phase_t  phase;
    mcWord_t mcode;
    byte_t   opcode;
    logic    busy;
    logic    mcLast;
    logic    mcHalt;

    busIf bus ();

    cenGen cenGen_i (.clk(clk), .rstN(rstN), .cenRise(cenRise), .cenFall(cenFall));

    phaseSeq phaseSeq_i (
        .clk(clk), .rstN(rstN), .cenRise(cenRise), .irq(irq), .busy(busy),
        .opcode(opcode), .mcLast(mcLast), .mcHalt(mcHalt), .phase(phase), .halted(halted)
    );

    mcRom mcRom_i (.clk(clk), .cenRise(cenRise), .phase(phase), .opcode(opcode), .mcode(mcode));

    execUnit execUnit_i (
        .clk(clk), .rstN(rstN), .cenFall(cenFall), .mcode(mcode), .bus(bus.core),
        .busy(busy), .opcode(opcode), .mcLast(mcLast), .mcHalt(mcHalt)
    );

    apbMaster apbMaster_i (
        .clk(clk), .rstN(rstN), .bus(bus.master), .paddr(paddr), .psel(psel),
        .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

endmodule

`default_nettype wire

//--- sim/tbApbMem.sv
// -------------------------------------------------------------------
// APB slave memory for the testbench. Adds 0 to 3 random wait states
// per transfer and logs every write and the address of every read
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tbApbMem import mcPkg::*; (
    input  wire        clk,
    input  wire addr_t paddr,
    input  wire        psel,
    input  wire        penable,
    input  wire        pwrite,
    input  wire byte_t pwdata,
    output byte_t      prdata,
    output logic       pready
);

    byte_t mem [0:65535];
    addr_t wrAddr [$]; // Write log, in bus order
    byte_t wrData [$];
    addr_t rdAddr [$];
    int    waitLeft;

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = byte_t'(i) ^ byte_t'(i >> 8) ^ 8'h5A;
        end
        waitLeft = 0;
        prdata   = '0;
        pready   = 1'b0;
    end

    // Slave outputs change on the falling edge only
    always @(negedge clk) begin
        pready = 1'b0;
        if (psel && !penable) begin
            waitLeft = int'($urandom % 4); // Setup phase
        end else if (psel && penable) begin
            if (waitLeft == 0) begin
                pready = 1'b1;
                prdata = mem[paddr];
            end else begin
                waitLeft = waitLeft - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (psel && penable && pready) begin
            if (pwrite) begin
                mem[paddr] = pwdata;
                wrAddr.push_back(paddr);
                wrData.push_back(pwdata);
            end else begin
                rdAddr.push_back(paddr);
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/mcCoreTb.sv
// -------------------------------------------------------------------
// Testbench for the microcoded core. Builds a random program in the
// APB memory, predicts its stores and interrupt pushes with a model
// and checks the bus traffic, the interrupt entry and the halt
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mcCoreTb import mcPkg::*; ();

    localparam int    N_INSTR    = 40;
    localparam int    WAIT_LIMIT = 2000 * CEN_DIV;
    localparam byte_t OP_BAD     = 8'h3F; // Outside the instruction set

    logic  clk;
    logic  rstN;
    logic  irq;
    addr_t paddr;
    logic  psel;
    logic  penable;
    logic  pwrite;
    byte_t pwdata;
    byte_t prdata;
    logic  pready;
    logic  halted;

    byte_t kind  [0:N_INSTR-1];
    byte_t imm   [0:N_INSTR-1];
    addr_t opnd  [0:N_INSTR-1];
    int    jmpTo [0:N_INSTR-1]; // Index of the next instruction on the path
    addr_t iAddr [0:N_INSTR];
    addr_t expAddr [$];
    byte_t expData [$];
    byte_t expA;
    addr_t resumeAddr;

    mcCore mcCore_i (
        .clk(clk), .rstN(rstN), .irq(irq), .paddr(paddr), .psel(psel),
        .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .halted(halted)
    );

    tbApbMem tbApbMem (
        .clk(clk), .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkAddr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abortRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkByte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            abortRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic waitReads(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (tbApbMem.rdAddr.size() < n && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (tbApbMem.rdAddr.size() < n) begin
            abortRun($sformatf("Timeout: %0d APB reads seen, waited for %0d",
                               tbApbMem.rdAddr.size(), n));
        end
    endtask

    task automatic waitWrites(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (tbApbMem.wrAddr.size() < n && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (tbApbMem.wrAddr.size() < n) begin
            abortRun($sformatf("Timeout: %0d APB writes seen, waited for %0d",
                               tbApbMem.wrAddr.size(), n));
        end
    endtask

    task automatic waitHalt(input int limit);
        int cycles;
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            abortRun("Timeout: the core never raised halted");
        end
    endtask

    function automatic int opLen(input byte_t op);
        if (op == OP_LDAI || op == OP_ADDI) begin
            return 2;
        end else if (op == OP_STAE || op == OP_JMPE) begin
            return 3;
        end
        return 1;
    endfunction

    task automatic putByte(input addr_t a, input byte_t d);
        tbApbMem.mem[a] = d;
    endtask

    task automatic buildProgram();
        addr_t pc;
        int    r;
        pc = 16'h0400 + addr_t'($urandom % 256);
        for (int i = 0; i < N_INSTR; i++) begin
            r = int'($urandom % 5);
            case (r)
                0:       kind[i] = OP_LDAI;
                1:       kind[i] = OP_ADDI;
                2:       kind[i] = OP_STAE;
                3:       kind[i] = OP_JMPE;
                default: kind[i] = OP_NOP;
            endcase
            if (i < 2 && (kind[i] == OP_JMPE || kind[i] == OP_STAE)) begin
                kind[i] = OP_LDAI; // No store or jump ahead of the store at 2
            end
            if (i == 2) begin
                kind[i] = OP_STAE; // The interrupt is raised after this store
            end
            iAddr[i] = pc;
            pc = pc + addr_t'(opLen(kind[i]));
        end
        iAddr[N_INSTR] = pc;
        for (int i = 0; i < N_INSTR; i++) begin
            imm[i]   = byte_t'($urandom);
            opnd[i]  = 16'h0200 | addr_t'($urandom % 256);
            jmpTo[i] = i + 1;
            if (kind[i] == OP_JMPE) begin
                jmpTo[i] = i + 1 + int'($urandom % (N_INSTR - i)); // Forward only
                opnd[i]  = iAddr[jmpTo[i]];
            end
            putByte(iAddr[i], kind[i]);
            if (opLen(kind[i]) == 2) begin
                putByte(iAddr[i] + 16'd1, imm[i]);
            end else if (opLen(kind[i]) == 3) begin
                putByte(iAddr[i] + 16'd1, opnd[i][15:8]); // High byte first
                putByte(iAddr[i] + 16'd2, opnd[i][7:0]);
            end
        end
        putByte(iAddr[N_INSTR], OP_BAD);
        resumeAddr = iAddr[3];
        putByte(RESET_VEC, iAddr[0][15:8]);
        putByte(RESET_VEC + 16'd1, iAddr[0][7:0]);
        putByte(IRQ_VEC, resumeAddr[15:8]); // Handler is the rest of the program
        putByte(IRQ_VEC + 16'd1, resumeAddr[7:0]);
    endtask

    task automatic runModel();
        byte_t a;
        int    i;
        a = 8'h00;
        i = 0;
        while (i < N_INSTR) begin
            if (kind[i] == OP_LDAI) begin
                a = imm[i];
            end else if (kind[i] == OP_ADDI) begin
                a = a + imm[i]; // Wraps at 256
            end else if (kind[i] == OP_STAE) begin
                expAddr.push_back(opnd[i]);
                expData.push_back(a);
                if (i == 2) begin
                    expAddr.push_back(STACK_TOP);
                    expData.push_back(resumeAddr[7:0]);
                    expAddr.push_back(STACK_TOP - 16'd1);
                    expData.push_back(resumeAddr[15:8]);
                    expAddr.push_back(STACK_TOP - 16'd2);
                    expData.push_back(a);
                end
            end
            i = jmpTo[i];
        end
        expA = a;
    endtask

    initial begin
        int   nRd;
        logic busAfterHalt;
        void'($urandom(20));
        rstN    = 1'b0;
        irq     = 1'b0;
        @(negedge clk);
        buildProgram();
        runModel();
        $display("Program at 0x%h, %0d writes expected", iAddr[0], expAddr.size());
        repeat (7) @(negedge clk);
        rstN = 1'b1;

        waitReads(1, 4 * CEN_DIV + 8);
        waitReads(3, WAIT_LIMIT);
        checkAddr("paddr", tbApbMem.rdAddr[0], RESET_VEC);
        checkAddr("paddr", tbApbMem.rdAddr[1], RESET_VEC + 16'd1);
        checkAddr("paddr", tbApbMem.rdAddr[2], iAddr[0]);

        waitWrites(1, WAIT_LIMIT);
        irq = 1'b1;
        waitWrites(4, WAIT_LIMIT); // Store plus three pushes
        nRd = tbApbMem.rdAddr.size();
        waitReads(nRd + 3, WAIT_LIMIT);
        checkAddr("paddr", tbApbMem.rdAddr[nRd], IRQ_VEC);
        checkAddr("paddr", tbApbMem.rdAddr[nRd + 1], IRQ_VEC + 16'd1);
        checkAddr("paddr", tbApbMem.rdAddr[nRd + 2], resumeAddr);
        irq = 1'b0;
        repeat (2 * CEN_DIV) @(negedge clk);
        irq = 1'b1; // Masked, must not push again

        waitHalt(WAIT_LIMIT);
        busAfterHalt = 1'b0;
        for (int k = 0; k < 8 * CEN_DIV; k++) begin
            @(negedge clk);
            busAfterHalt = busAfterHalt | psel;
        end
        if (busAfterHalt) begin
            abortRun("An APB transfer started after the core halted");
        end
        checkAddr("paddr", tbApbMem.rdAddr[tbApbMem.rdAddr.size() - 1], iAddr[N_INSTR]);

        for (int k = 0; k < expAddr.size() && k < tbApbMem.wrAddr.size(); k++) begin
            checkAddr("paddr", tbApbMem.wrAddr[k], expAddr[k]);
            checkByte("pwdata", tbApbMem.wrData[k], expData[k]);
        end
        if (tbApbMem.wrAddr.size() != expAddr.size()) begin
            abortRun($sformatf("The core made %0d APB writes where %0d were expected",
                               tbApbMem.wrAddr.size(), expAddr.size()));
        end
        checkByte("A", mcCore_i.execUnit_i.a, expA);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
hw/mcPkg.sv
hw/busIf.sv
hw/cenGen.sv
hw/phaseSeq.sv
hw/mcRom.sv
hw/execUnit.sv
hw/apbMaster.sv
hw/mcCore.sv
sim/tbApbMem.sv
sim/mcCoreTb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run; exit status is the simulation result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module mcCoreTb -f project.f \
    && ./obj_dir/VmcCoreTb \
    || { echo "simulation failed"; exit 1; }
